//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the IN subsystem regression with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_usb_in -o tb_usb_in
./obj_dir/tb_usb_in

//--- sim.f
usb_pkg.sv
usb_in_cfg_pkg.sv
usb_in_ep_buffer.sv
usb_in_pe.sv
usb_tx_sender.sv
usb_in_top.sv
tb_clk_gen.sv
usb_in_checker.sv
tb_usb_in.sv

//--- tb_clk_gen.sv
// Testbench clock and reset source
// 4 ns clock, active-low reset held for the first 5 cycles
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 250 MHz sim clock, models the 48 MHz domain
  end

  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // Release away from the active edge
  end

endmodule

`default_nettype wire

//--- tb_usb_in.sv
// Testbench top for the IN subsystem
// Host token tasks, a software fill model and a reference model for pids, bytes, toggles
`default_nettype none

module tb_usb_in;

  timeunit 1ns;
  timeprecision 100ps;

  import usb_pkg::*;
  import usb_in_cfg_pkg::*;

  logic clk, rst_n, link_active, link_reset;
  logic [6:0] dev_addr;
  usb_rx_pkt_t rx_pkt;
  usb_ep_cfg_t ep_cfg;
  usb_fill_t fill;
  usb_commit_t commit;
  usb_datatog_wr_t tog_wr;
  usb_tx_out_t tx_o;
  logic [3:0] data_toggle;
  usb_in_events_t events;

  // Reference model
  logic [7:0] exp_data [4][8];
  int         exp_len [4];
  logic [3:0] exp_has, exp_toggle;
  usb_in_events_t last_ev;  // Events in the cycle of the last token end
  integer seed = 28;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  usb_in_top i_dut (
    .clk_48mhz_i (clk), .rst_ni (rst_n), .dev_addr_i (dev_addr),
    .link_active_i (link_active), .link_reset_i (link_reset),
    .rx_pkt_i (rx_pkt), .ep_cfg_i (ep_cfg), .fill_i (fill), .commit_i (commit),
    .datatog_wr_i (tog_wr), .tx_o (tx_o), .data_toggle_o (data_toggle), .events_o (events)
  );

  bind usb_in_top usb_in_checker i_checker (
    .clk_48mhz_i (clk_48mhz_i), .rst_ni (rst_ni), .dev_addr_i (dev_addr_i),
    .link_reset_i (link_reset_i), .rx_pkt_i (rx_pkt_i), .ep_cfg_i (ep_cfg_i),
    .tx_o (tx_o), .data_toggle_o (data_toggle_o), .events_o (events_o)
  );

  always @(posedge clk) begin
    if (i_dut.i_checker.fail_q) begin
      $display("Regression failed");
      $fatal(1, "a bound protocol assertion fired");
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("error at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
      $display("Regression failed");
      $fatal(1, "stopping on a value mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("Regression failed");
    $fatal(1, what);
  endtask

  // Response the host should see, from the tb copy of the config
  function automatic logic [3:0] model_pid(input int ep);
    if (ep_cfg.iso[ep]) return UsbPidData0;
    if (ep_cfg.stall[ep]) return UsbPidStall;
    if (exp_has[ep]) return exp_toggle[ep] ? UsbPidData1 : UsbPidData0;
    return UsbPidNak;
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic load_packet(input int ep, input int len);
    logic [7:0] b;
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      b = 8'($random(seed));
      fill = '{we: 1'b1, ep: 2'(ep), addr: 3'(i), data: b};
      exp_data[ep][i] = b;
    end
    @(negedge clk);
    fill.we = 1'b0;
    commit  = '{valid: 1'b1, ep: 2'(ep), len: 4'(len)};
    @(negedge clk);
    commit.valid = 1'b0;
    exp_len[ep]  = len;
    exp_has[ep]  = 1'b1;
  endtask

  // Start strobe, then the end strobe; returns on the negedge after the end
  task automatic send_token(input logic [3:0] pid, input logic [6:0] addr, input logic [3:0] ep);
    @(negedge clk);
    rx_pkt = '{pkt_start: 1'b1, default: '0};
    @(negedge clk);
    rx_pkt = '{pkt_start: 1'b0, pkt_end: 1'b1, valid: 1'b1, pid: pid, addr: addr, endp: ep};
    #1;
    last_ev = events;
    check_val("tx_o.pkt_start", 0, 32'(tx_o.pkt_start));  // Not in the token cycle
    @(negedge clk);
    rx_pkt = '0;
  endtask

  task automatic wait_pkt_end();
    int n;
    n = 0;
    while (!tx_o.pkt_end) begin
      @(negedge clk);
      #1;
      n++;
      if (n > 100) give_up("timeout waiting for tx_o.pkt_end");
    end
  endtask

  task automatic collect_data(input int ep, input int len, output logic saw_done);
    int n;
    int idx;
    n = 0;
    idx = 0;
    saw_done = 1'b0;
    do begin
      @(negedge clk);
      #1;
      if (events.xact_done) saw_done = 1'b1;
      if (tx_o.byte_valid) begin
        if (idx >= len) give_up("more payload bytes than committed");
        check_val("tx_o.byte_data", 32'(exp_data[ep][idx]), 32'(tx_o.byte_data));
        idx++;
      end
      n++;
      if (n > 100) give_up("timeout waiting for the end of a data packet");
    end while (!tx_o.pkt_end);
    check_val("payload length", 32'(len), 32'(idx));
  endtask

  task automatic do_in(input int ep);
    logic [3:0] pid;
    logic done;
    pid = model_pid(ep);
    send_token(UsbPidIn, dev_addr, 4'(ep));
    #1;
    check_val("tx_o.pkt_start", 1, 32'(tx_o.pkt_start));
    check_val("tx_o.pid", 32'(pid), 32'(tx_o.pid));
    check_val("events_o.nodata", 32'(!exp_has[ep]), 32'(events.nodata));
    if (pid[1:0] == 2'b11) begin
      collect_data(ep, exp_has[ep] ? exp_len[ep] : 0, done);
      if (ep_cfg.iso[ep]) begin
        check_val("events_o.xact_done", 32'(exp_has[ep]), 32'(done));
        exp_has[ep] = 1'b0;
      end
    end else begin
      wait_pkt_end();
    end
  endtask

  task automatic host_ack(input int ep);
    send_token(UsbPidAck, 7'd0, 4'd0);
    check_val("events_o.xact_done", 1, 32'(last_ev.xact_done));
    exp_toggle[ep] = ~exp_toggle[ep];
    exp_has[ep]    = 1'b0;
    #1;
    check_val("data_toggle_o", 32'(exp_toggle), 32'(data_toggle));
  endtask

  task automatic expect_silent(input logic [6:0] addr, input logic [3:0] ep);
    send_token(UsbPidIn, addr, ep);
    repeat (6) begin
      #1;
      check_val("tx_o.pkt_start", 0, 32'(tx_o.pkt_start));
      @(negedge clk);
    end
  endtask

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    int n;
    dev_addr = 7'h05;
    link_active = 1'b1;
    link_reset = 1'b0;
    rx_pkt = '0;
    fill = '0;
    commit = '0;
    tog_wr = '0;
    ep_cfg = '{enabled: 4'b1011, stall: 4'b1000, iso: 4'b0010};  // ep2 off, ep3 stall, ep1 iso
    exp_has = '0;
    exp_toggle = '0;
    n = 0;
    while (!rst_n) begin
      @(negedge clk);
      n++;
      if (n > 20) give_up("reset never released");
    end

    // Bulk IN, ACK, then NAK with nodata
    load_packet(0, 5);
    do_in(0);
    host_ack(0);
    do_in(0);

    // Missing ACK times out, retry resends, host NAK pulses nak
    load_packet(0, 8);
    do_in(0);
    n = 0;
    while (!events.timeout) begin
      @(negedge clk);
      #1;
      n++;
      if (n > 200) give_up("timeout event never came");
    end
    do_in(0);
    send_token(UsbPidNak, 7'd0, 4'd0);
    check_val("events_o.nak", 1, 32'(last_ev.nak));
    do_in(0);
    host_ack(0);

    // Stall, disabled, unimplemented, foreign address
    do_in(3);
    expect_silent(dev_addr, 4'd2);
    expect_silent(dev_addr, 4'd7);
    expect_silent(7'h06, 4'd0);

    // Isochronous, with data and empty
    load_packet(1, 4);
    do_in(1);
    do_in(1);

    // SETUP, software write, link reset
    send_token(UsbPidSetup, dev_addr, 4'd0);
    exp_toggle[0] = 1'b1;
    #1;
    check_val("data_toggle_o", 32'(exp_toggle), 32'(data_toggle));
    load_packet(0, 3);
    do_in(0);
    host_ack(0);
    @(negedge clk);
    tog_wr = '{we: 1'b1, status: 4'b1111, mask: 4'b0101};
    @(negedge clk);
    tog_wr = '0;
    exp_toggle = exp_toggle | 4'b0101;
    #1;
    check_val("data_toggle_o", 32'(exp_toggle), 32'(data_toggle));
    // Clear ep2 only, ep0 must keep its 1
    @(negedge clk);
    tog_wr = '{we: 1'b1, status: 4'b0000, mask: 4'b0100};
    @(negedge clk);
    tog_wr = '0;
    exp_toggle[2] = 1'b0;
    #1;
    check_val("data_toggle_o", 32'(exp_toggle), 32'(data_toggle));
    @(negedge clk);
    link_reset = 1'b1;
    @(negedge clk);
    link_reset = 1'b0;
    exp_toggle = '0;
    #1;
    check_val("data_toggle_o", 32'(exp_toggle), 32'(data_toggle));

    repeat (4) @(negedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- usb_in_cfg_pkg.sv
// Device configuration for the IN path
// Sizes, timing constants and the packed structs on the top-level ports
`default_nettype none

package usb_in_cfg_pkg;

  //////////////////////////////
  // Sizes and timing
  //////////////////////////////

  localparam int unsigned NumInEps         = 4;
  localparam int unsigned InEpW            = 2;   // Endpoint index width
  localparam int unsigned MaxInPktSizeByte = 8;
  localparam int unsigned PktW             = 3;   // Byte offset width
  localparam int unsigned AckTimeoutCnt    = 73;  // Countdown start, counted down to 0
  localparam int unsigned AckTimeoutCntW   = 7;
  localparam int unsigned TxByteCycles     = 4;   // Clocks per byte on the line
  localparam int unsigned TxTailBytes      = 2;   // CRC16 plus EOP time
  localparam int unsigned TxCntW           = 3;   // Sender pacing counter width

  //////////////////////////////
  // Port structs
  //////////////////////////////

  // Token or handshake from the receiver
  typedef struct packed {
    logic       pkt_start;  // Strobe, SOP seen
    logic       pkt_end;    // Strobe, packet complete
    logic       valid;      // Qualifies pkt_end
    logic [3:0] pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } usb_rx_pkt_t;

  typedef struct packed {
    logic [NumInEps-1:0] enabled;
    logic [NumInEps-1:0] stall;
    logic [NumInEps-1:0] iso;
  } usb_ep_cfg_t;

  // Software byte write into the packet buffer
  typedef struct packed {
    logic             we;
    logic [InEpW-1:0] ep;
    logic [PktW-1:0]  addr;
    logic [7:0]       data;
  } usb_fill_t;

  typedef struct packed {
    logic             valid;
    logic [InEpW-1:0] ep;
    logic [3:0]       len;  // 0 to MaxInPktSizeByte
  } usb_commit_t;

  typedef struct packed {
    logic                we;
    logic [NumInEps-1:0] status;
    logic [NumInEps-1:0] mask;
  } usb_datatog_wr_t;

  typedef struct packed {
    logic       pkt_start;
    logic [3:0] pid;
    logic       byte_valid;
    logic [7:0] byte_data;
    logic       pkt_end;
  } usb_tx_out_t;

  typedef struct packed {
    logic timeout;
    logic nak;
    logic nodata;
    logic xact_done;
  } usb_in_events_t;

endpackage

`default_nettype wire

//--- usb_in_checker.sv
// Protocol checks on the IN subsystem ports, bound into usb_in_top
// Flags fail_q and raises $error when a rule is broken
`default_nettype none

module usb_in_checker (
  input logic                          clk_48mhz_i,
  input logic                          rst_ni,
  input logic [6:0]                    dev_addr_i,
  input logic                          link_reset_i,
  input usb_in_cfg_pkg::usb_rx_pkt_t   rx_pkt_i,
  input usb_in_cfg_pkg::usb_ep_cfg_t   ep_cfg_i,
  input usb_in_cfg_pkg::usb_tx_out_t   tx_o,
  input logic [3:0]                    data_toggle_o,
  input usb_in_cfg_pkg::usb_in_events_t events_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import usb_pkg::*;
  import usb_in_cfg_pkg::*;

  logic fail_q = 1'b0;  // Polled by the testbench top
  logic tok_ok;         // Token to us, for an implemented and enabled endpoint
  logic in_tok;         // IN to us for an implemented endpoint, enabled or not
  logic hs_start;       // Handshake response leaving

  assign tok_ok = rx_pkt_i.pkt_end && rx_pkt_i.valid && (rx_pkt_i.addr == dev_addr_i) &&
                  (rx_pkt_i.endp < 4'(NumInEps)) && ep_cfg_i.enabled[rx_pkt_i.endp[1:0]];

  assign in_tok = rx_pkt_i.pkt_end && rx_pkt_i.valid && (rx_pkt_i.addr == dev_addr_i) &&
                  (rx_pkt_i.endp < 4'(NumInEps)) && (rx_pkt_i.pid == UsbPidIn);

  assign hs_start = tx_o.pkt_start && (tx_o.pid[1:0] == UsbPidTypeHandshake);

  //////////////////////////////
  // Response timing
  //////////////////////////////

  // Every response follows an IN token by exactly one cycle
  a_start_after_in: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    tx_o.pkt_start |-> $past(tok_ok && (rx_pkt_i.pid == UsbPidIn)))
    else begin
      fail_q = 1'b1;
      $error("pkt_start without a preceding IN token");
    end

  // NAK and STALL take one byte time on the line
  a_hs_len: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    $past(hs_start, TxByteCycles) |-> tx_o.pkt_end)
    else begin
      fail_q = 1'b1;
      $error("handshake packet did not end one byte time after its start");
    end

  a_nodata_src: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    events_o.nodata |-> $past(in_tok))
    else begin
      fail_q = 1'b1;
      $error("nodata without an IN token to an implemented endpoint");
    end

  //////////////////////////////
  // Toggles and events
  //////////////////////////////

  a_setup_toggle: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    (tok_ok && (rx_pkt_i.pid == UsbPidSetup) && !link_reset_i)
      |=> data_toggle_o[$past(rx_pkt_i.endp[1:0])])
    else begin
      fail_q = 1'b1;
      $error("SETUP did not set the toggle");
    end

  a_reset_toggle: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    link_reset_i |=> (data_toggle_o == '0))
    else begin
      fail_q = 1'b1;
      $error("link reset left a toggle set");
    end

  // Reply window of AckTimeoutCnt+1 cycles after the data packet, event one cycle later
  a_tmo_window: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    events_o.timeout |-> $past(tx_o.pkt_end, AckTimeoutCnt + 2))
    else begin
      fail_q = 1'b1;
      $error("timeout event not at the end of the ACK window");
    end

endmodule

`default_nettype wire

//--- usb_in_ep_buffer.sv
// One-packet store per IN endpoint, filled and committed by software
// Read by the protocol engine at its get offset, released on a good transaction end
`default_nettype none

module usb_in_ep_buffer (
  input  logic                                  clk_48mhz_i,
  input  logic                                  rst_ni,
  input  usb_in_cfg_pkg::usb_fill_t             fill_i,
  input  usb_in_cfg_pkg::usb_commit_t           commit_i,
  input  logic [usb_in_cfg_pkg::InEpW-1:0]      ep_cur_i,    // Endpoint of the transaction
  input  logic [usb_in_cfg_pkg::PktW-1:0]       get_addr_i,  // Offset to read
  input  logic                                  xact_end_i,  // Good end, free the packet
  output logic [usb_in_cfg_pkg::NumInEps-1:0]   has_data_o,
  output logic                                  data_done_o,
  output logic [7:0]                            rd_data_o
);

  import usb_in_cfg_pkg::*;

  logic [7:0]          mem_q [NumInEps][MaxInPktSizeByte];  // Payload bytes
  logic [3:0]          len_q [NumInEps];                    // Committed length
  logic [NumInEps-1:0] has_data_q;

  logic fill_ok;

  // Committed packets are locked until released, so a retry resends them intact
  assign fill_ok = fill_i.we & ~has_data_q[fill_i.ep];

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk_48mhz_i) begin
    if (fill_ok) begin
      mem_q[fill_i.ep][fill_i.addr] <= fill_i.data;
    end
  end

  // Length and ownership per endpoint
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      has_data_q <= '0;
      for (int i = 0; i < NumInEps; i++) begin
        len_q[i] <= '0;
      end
    end else begin
      if (xact_end_i) begin
        has_data_q[ep_cur_i] <= 1'b0;  // Host took the packet
      end
      // Commit after release, so a same-cycle commit wins
      if (commit_i.valid) begin
        has_data_q[commit_i.ep] <= 1'b1;
        len_q[commit_i.ep]      <= commit_i.len;
      end
    end
  end

  //////////////////////////////
  // Read side
  //////////////////////////////

  assign has_data_o  = has_data_q;
  assign data_done_o = {1'b0, get_addr_i} >= len_q[ep_cur_i];  // Offset past the payload
  assign rd_data_o   = mem_q[ep_cur_i][get_addr_i];             // Comb, engine registers it

endmodule

`default_nettype wire

//--- usb_in_pe.sv
// IN transaction protocol engine
// Decodes IN and SETUP tokens, picks DATAx, NAK or STALL, waits for the ACK
// and owns the data toggles and the event strobes
`default_nettype none

module usb_in_pe (
  input  logic                                  clk_48mhz_i,
  input  logic                                  rst_ni,
  input  logic                                  link_reset_i,
  input  logic                                  link_active_i,
  input  logic [6:0]                            dev_addr_i,
  input  usb_in_cfg_pkg::usb_rx_pkt_t           rx_pkt_i,
  input  usb_in_cfg_pkg::usb_ep_cfg_t           ep_cfg_i,
  input  usb_in_cfg_pkg::usb_datatog_wr_t       datatog_wr_i,
  output logic [usb_in_cfg_pkg::InEpW-1:0]      in_ep_current_o,
  output logic [usb_in_cfg_pkg::PktW-1:0]       in_ep_get_addr_o,
  output logic                                  in_ep_xact_end_o,  // Good end
  output logic                                  in_ep_rollback_o,  // Bad end, keep packet
  input  logic [usb_in_cfg_pkg::NumInEps-1:0]   in_ep_has_data_i,
  input  logic                                  in_ep_data_done_i,
  input  logic [7:0]                            in_ep_data_i,
  output logic                                  tx_pkt_start_o,
  output logic [3:0]                            tx_pid_o,
  output logic                                  tx_data_avail_o,
  input  logic                                  tx_data_get_i,
  input  logic                                  tx_pkt_end_i,
  output logic [7:0]                            tx_data_o,
  output logic [usb_in_cfg_pkg::NumInEps-1:0]   in_data_toggle_o,
  output usb_in_cfg_pkg::usb_in_events_t        events_o
);

  import usb_pkg::*;
  import usb_in_cfg_pkg::*;

  typedef enum logic [2:0] {
    StIdle,
    StRcvdIn,
    StSendData,
    StWaitTxEnd,
    StWaitAckStart,
    StWaitAck
  } state_e;

  state_e state_q, state_d;

  logic [AckTimeoutCntW-1:0] tmo_q, tmo_d;
  logic [NumInEps-1:0]       toggle_q, toggle_d;
  logic [InEpW-1:0]          ep_idx_d;

  logic          pkt_rcvd, token_rcvd, setup_rcvd, in_rcvd, ack_rcvd, nak_rcvd;
  logic          ep_in_hw, ep_active, in_start;
  logic          has_data_q, more_data, last_get;
  logic          xact_end, rollback_d, timeout_q, nodata_q;
  usb_pid_e      rx_pid;
  usb_pid_type_e rx_pid_type;

  //////////////////////////////
  // Token decode
  //////////////////////////////

  assign rx_pid      = usb_pid_e'(rx_pkt_i.pid);
  assign rx_pid_type = usb_pid_type_e'(rx_pkt_i.pid[1:0]);

  assign pkt_rcvd   = rx_pkt_i.pkt_end & rx_pkt_i.valid;
  assign token_rcvd = pkt_rcvd && (rx_pid_type == UsbPidTypeToken) &&
                      (rx_pkt_i.addr == dev_addr_i);  // Only our address
  assign setup_rcvd = token_rcvd && (rx_pid == UsbPidSetup);
  assign in_rcvd    = token_rcvd && (rx_pid == UsbPidIn);
  assign ack_rcvd   = pkt_rcvd && (rx_pid == UsbPidAck);
  assign nak_rcvd   = pkt_rcvd && (rx_pid == UsbPidNak);

  // Endpoints above NumInEps-1 are not implemented
  assign ep_in_hw  = rx_pkt_i.endp < 4'(NumInEps);
  assign ep_idx_d  = ep_in_hw ? rx_pkt_i.endp[InEpW-1:0] : '0;
  assign ep_active = ep_in_hw & ep_cfg_i.enabled[ep_idx_d];
  assign in_start  = (state_q == StIdle) && in_rcvd;

  // Payload left to send for the captured endpoint
  assign more_data       = has_data_q & ~in_ep_data_done_i;
  assign tx_data_avail_o = (state_q == StSendData) & more_data;
  assign last_get        = (&in_ep_get_addr_o) & tx_data_get_i;  // Offset would wrap

  //////////////////////////////
  // Transaction FSM
  //////////////////////////////

  always_comb begin
    state_d        = state_q;
    tmo_d          = AckTimeoutCnt[AckTimeoutCntW-1:0];  // Rearmed outside the wait
    xact_end       = 1'b0;
    rollback_d     = 1'b0;
    tx_pkt_start_o = 1'b0;
    tx_pid_o       = 4'b0000;
    unique case (state_q)
      StIdle: begin
        if (in_start && ep_active) begin
          state_d = StRcvdIn;  // Silent for inactive endpoints
        end
      end
      StRcvdIn: begin
        tx_pkt_start_o = 1'b1;
        if (ep_cfg_i.iso[in_ep_current_o]) begin
          // ISO always answers, zero-length packet when empty
          state_d  = StSendData;
          tx_pid_o = UsbPidData0;
        end else if (ep_cfg_i.stall[in_ep_current_o]) begin
          state_d  = StIdle;
          tx_pid_o = UsbPidStall;
        end else if (has_data_q) begin
          state_d  = StSendData;
          tx_pid_o = toggle_q[in_ep_current_o] ? UsbPidData1 : UsbPidData0;
        end else begin
          state_d  = StIdle;
          tx_pid_o = UsbPidNak;
        end
      end
      StSendData: begin
        if (!more_data || last_get) begin
          if (ep_cfg_i.iso[in_ep_current_o]) begin
            state_d  = StIdle;      // No handshake phase
            xact_end = has_data_q;  // Empty ISO frames complete nothing
          end else if (tx_pkt_end_i) begin
            state_d = StWaitAckStart;
          end else begin
            state_d = StWaitTxEnd;
          end
        end
      end
      StWaitTxEnd: begin
        if (tx_pkt_end_i) begin
          state_d = StWaitAckStart;
        end
      end
      StWaitAckStart: begin
        tmo_d = tmo_q - 1'b1;  // Host reply window
        if (rx_pkt_i.pkt_start) begin
          state_d = StWaitAck;
        end else if (tmo_q == '0) begin
          state_d    = StIdle;
          rollback_d = 1'b1;
        end
      end
      StWaitAck: begin
        if (ack_rcvd) begin
          state_d  = StIdle;
          xact_end = 1'b1;
        end else if (rx_pkt_i.pkt_end) begin
          state_d    = StIdle;  // NAK or garbage, retry later
          rollback_d = 1'b1;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= StIdle;
      tmo_q            <= AckTimeoutCnt[AckTimeoutCntW-1:0];
      in_ep_rollback_o <= 1'b0;
      timeout_q        <= 1'b0;
    end else if (link_reset_i || !link_active_i) begin
      state_q          <= StIdle;  // Abandon silently
      tmo_q            <= AckTimeoutCnt[AckTimeoutCntW-1:0];
      in_ep_rollback_o <= 1'b0;
      timeout_q        <= 1'b0;
    end else begin
      state_q          <= state_d;
      tmo_q            <= tmo_d;
      in_ep_rollback_o <= rollback_d;
      timeout_q        <= rollback_d & (state_q == StWaitAckStart);  // Reply window ran out
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_ep_get_addr_o <= '0;
      in_ep_current_o  <= '0;
      has_data_q       <= 1'b0;
      nodata_q         <= 1'b0;
    end else begin
      if (state_q == StIdle) begin
        in_ep_get_addr_o <= '0;
      end else if ((state_q == StSendData) && tx_data_get_i) begin
        in_ep_get_addr_o <= in_ep_get_addr_o + 1'b1;
      end
      if (in_start) begin
        in_ep_current_o <= ep_idx_d;                    // Latch for the whole transaction
        has_data_q      <= in_ep_has_data_i[ep_idx_d];  // Snapshot, software cannot race
      end
      // Counted for disabled endpoints too
      nodata_q <= in_start & ep_in_hw & ~in_ep_has_data_i[ep_idx_d];
    end
  end

  always_ff @(posedge clk_48mhz_i) begin
    tx_data_o <= in_ep_data_i;  // Byte lines up with the sender's byte_valid
  end

  //////////////////////////////
  // Data toggles
  //////////////////////////////

  always_comb begin
    toggle_d = toggle_q;
    if (setup_rcvd && ep_active) begin
      toggle_d[ep_idx_d] = 1'b1;  // Control data stage starts at DATA1
    end else if ((state_q == StWaitAck) && ack_rcvd) begin
      toggle_d[in_ep_current_o] = ~toggle_q[in_ep_current_o];
    end
    // Software last, selected bits only
    if (datatog_wr_i.we) begin
      toggle_d = (toggle_d & ~datatog_wr_i.mask) | (datatog_wr_i.status & datatog_wr_i.mask);
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_q <= '0;
    end else if (link_reset_i) begin
      toggle_q <= '0;  // Bus reset restarts every pipe at DATA0
    end else begin
      toggle_q <= toggle_d;
    end
  end

  assign in_data_toggle_o = toggle_q;

  // Events
  assign in_ep_xact_end_o   = xact_end;
  assign events_o.timeout   = timeout_q;
  assign events_o.nak       = (state_q == StWaitAck) && nak_rcvd;
  assign events_o.nodata    = nodata_q;
  assign events_o.xact_done = xact_end;

endmodule

`default_nettype wire

//--- usb_in_top.sv
// IN transaction subsystem top
// Endpoint buffer feeds the protocol engine, which drives the byte sender
`default_nettype none

module usb_in_top (
  input  logic                                  clk_48mhz_i,
  input  logic                                  rst_ni,
  input  logic [6:0]                            dev_addr_i,
  input  logic                                  link_active_i,
  input  logic                                  link_reset_i,
  input  usb_in_cfg_pkg::usb_rx_pkt_t           rx_pkt_i,
  input  usb_in_cfg_pkg::usb_ep_cfg_t           ep_cfg_i,
  input  usb_in_cfg_pkg::usb_fill_t             fill_i,
  input  usb_in_cfg_pkg::usb_commit_t           commit_i,
  input  usb_in_cfg_pkg::usb_datatog_wr_t       datatog_wr_i,
  output usb_in_cfg_pkg::usb_tx_out_t           tx_o,
  output logic [usb_in_cfg_pkg::NumInEps-1:0]   data_toggle_o,
  output usb_in_cfg_pkg::usb_in_events_t        events_o
);

  import usb_in_cfg_pkg::*;

  // Buffer to engine
  logic [InEpW-1:0]    ep_current;
  logic [PktW-1:0]     get_addr;
  logic                xact_end;
  logic [NumInEps-1:0] has_data;
  logic                data_done;
  logic [7:0]          rd_data;

  // Engine to sender
  logic       tx_pkt_start, tx_data_avail, tx_data_get, tx_pkt_end;
  logic [3:0] tx_pid;
  logic [7:0] tx_data;

  usb_in_ep_buffer i_ep_buffer (
    .clk_48mhz_i (clk_48mhz_i),
    .rst_ni      (rst_ni),
    .fill_i      (fill_i),
    .commit_i    (commit_i),
    .ep_cur_i    (ep_current),
    .get_addr_i  (get_addr),
    .xact_end_i  (xact_end),
    .has_data_o  (has_data),
    .data_done_o (data_done),
    .rd_data_o   (rd_data)
  );

  usb_in_pe i_in_pe (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .link_reset_i      (link_reset_i),
    .link_active_i     (link_active_i),
    .dev_addr_i        (dev_addr_i),
    .rx_pkt_i          (rx_pkt_i),
    .ep_cfg_i          (ep_cfg_i),
    .datatog_wr_i      (datatog_wr_i),
    .in_ep_current_o   (ep_current),
    .in_ep_get_addr_o  (get_addr),
    .in_ep_xact_end_o  (xact_end),
    .in_ep_rollback_o  (),  // Packet stays committed, nothing to undo here
    .in_ep_has_data_i  (has_data),
    .in_ep_data_done_i (data_done),
    .in_ep_data_i      (rd_data),
    .tx_pkt_start_o    (tx_pkt_start),
    .tx_pid_o          (tx_pid),
    .tx_data_avail_o   (tx_data_avail),
    .tx_data_get_i     (tx_data_get),
    .tx_pkt_end_i      (tx_pkt_end),
    .tx_data_o         (tx_data),
    .in_data_toggle_o  (data_toggle_o),
    .events_o          (events_o)
  );

  usb_tx_sender i_tx_sender (
    .clk_48mhz_i     (clk_48mhz_i),
    .rst_ni          (rst_ni),
    .tx_pkt_start_i  (tx_pkt_start),
    .tx_pid_i        (tx_pid),
    .tx_data_avail_i (tx_data_avail),
    .tx_data_i       (tx_data),
    .tx_data_get_o   (tx_data_get),
    .tx_pkt_end_o    (tx_pkt_end),
    .tx_o            (tx_o)
  );

endmodule

`default_nettype wire

//--- usb_pkg.sv
// USB protocol constants shared by the IN transaction blocks
// PID codes and PID type decode as the wire carries them
`default_nettype none

package usb_pkg;

  //////////////////////////////
  // Packet identifiers
  //////////////////////////////

  // Low nibble of the PID byte, the check nibble is stripped by the receiver
  typedef enum logic [3:0] {
    UsbPidOut   = 4'b0001,  // Token
    UsbPidIn    = 4'b1001,  // Token
    UsbPidSof   = 4'b0101,  // Token, frame start
    UsbPidSetup = 4'b1101,  // Token
    UsbPidData0 = 4'b0011,
    UsbPidData1 = 4'b1011,
    UsbPidAck   = 4'b0010,  // Handshake
    UsbPidNak   = 4'b1010,  // Handshake
    UsbPidStall = 4'b1110   // Handshake
  } usb_pid_e;

  // PID bits [1:0] give the packet class
  typedef enum logic [1:0] {
    UsbPidTypeSpecial   = 2'b00,
    UsbPidTypeToken     = 2'b01,
    UsbPidTypeHandshake = 2'b10,
    UsbPidTypeData      = 2'b11
  } usb_pid_type_e;

endpackage

`default_nettype wire

//--- usb_tx_sender.sv
// Transmit byte sender, models the serial line time of each packet
// Pulls payload bytes at a fixed byte rate and strobes the packet end
`default_nettype none

module usb_tx_sender (
  input  logic                          clk_48mhz_i,
  input  logic                          rst_ni,
  input  logic                          tx_pkt_start_i,
  input  logic [3:0]                    tx_pid_i,
  input  logic                          tx_data_avail_i,
  input  logic [7:0]                    tx_data_i,
  output logic                          tx_data_get_o,
  output logic                          tx_pkt_end_o,
  output usb_in_cfg_pkg::usb_tx_out_t   tx_o
);

  import usb_pkg::*;
  import usb_in_cfg_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StPayload,  // PID byte, then one byte per pacing period
    StTail      // CRC and EOP, or the handshake PID byte
  } state_e;

  state_e            state_q, state_d;
  logic [TxCntW-1:0] cnt_q, cnt_d;
  logic              get_q;

  always_comb begin
    state_d       = state_q;
    cnt_d         = cnt_q - 1'b1;
    tx_data_get_o = 1'b0;
    tx_pkt_end_o  = 1'b0;
    unique case (state_q)
      StIdle: begin
        cnt_d = TxCntW'(TxByteCycles - 1);
        if (tx_pkt_start_i) begin
          // Handshakes carry no payload and no CRC
          state_d = (usb_pid_type_e'(tx_pid_i[1:0]) == UsbPidTypeHandshake) ? StTail : StPayload;
        end
      end
      StPayload: begin
        if (cnt_q == '0) begin
          if (tx_data_avail_i) begin
            tx_data_get_o = 1'b1;
            cnt_d         = TxCntW'(TxByteCycles - 1);
          end else begin
            state_d = StTail;
            cnt_d   = TxCntW'(TxTailBytes * TxByteCycles - 1);
          end
        end
      end
      StTail: begin
        if (cnt_q == '0) begin
          tx_pkt_end_o = 1'b1;
          state_d      = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      cnt_q   <= '0;
      get_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      get_q   <= tx_data_get_o;  // Byte arrives one cycle after its get
    end
  end

  assign tx_o.pkt_start  = tx_pkt_start_i;
  assign tx_o.pid        = tx_pid_i;  // Valid with pkt_start
  assign tx_o.byte_valid = get_q;
  assign tx_o.byte_data  = tx_data_i;
  assign tx_o.pkt_end    = tx_pkt_end_o;

endmodule

`default_nettype wire
